// ==== test/mod113_trace.txt ====
// operand: 100 hex digits, most significant first
// residue: operand mod 113 in hex
0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 00
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 1d
0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000071 00
7100000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 00
70ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 70
f000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 0e
0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000001 01
0000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000070 70
00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000e1 70
8000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000 0f
0000000000000000000000000000000000000000000000000100000000000000000000000000000000000000000000000000 10
0101010101010101010101010101010101010101010101010101010101010101010101010101010101010101010101010101 01
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 34
c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3 52
abcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcdabcd 13
1234123412341234123412341234123412341234123412341234123412341234123412341234123412341234123412341234 5c

// ==== list.f ====
common/mod113_pkg.sv
rtl/operand_assembler.sv
rtl/wide_mod_reducer/chunk_residue.sv
rtl/wide_mod_reducer/wide_mod_reducer.sv
rtl/residue_fifo.sv
rtl/mod113_engine.sv
test/tb_mod113_engine.sv

// ==== Bender.yml ====
package:
  name: mod113_engine

sources:
  - common/mod113_pkg.sv
  - rtl/operand_assembler.sv
  - rtl/wide_mod_reducer/chunk_residue.sv
  - rtl/wide_mod_reducer/wide_mod_reducer.sv
  - rtl/residue_fifo.sv
  - rtl/mod113_engine.sv
  - target: test
    files:
      - test/tb_mod113_engine.sv

// ==== test/tb_mod113_engine.sv ====
`timescale 1ns/1ps

module tb_mod113_engine;

  localparam int beat_w = 16;
  localparam int fifo_depth = 4;
  localparam int num_beats = mod113_pkg::operand_w / beat_w;
  localparam int stall_ops = fifo_depth + 3;

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  logic [beat_w-1:0] in_data;
  logic res_valid;
  logic res_ready;
  mod113_pkg::residue_t res_data;

  mod113_pkg::operand_t ops[$];
  mod113_pkg::residue_t exps[$];
  mod113_pkg::residue_t exp_q[$]; // Residues of accepted operands, in input order
  int accepted_ops;

  mod113_engine #(
    .beat_w     (beat_w),
    .fifo_depth (fifo_depth)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped on first error");
  endtask

  task automatic check_residue(input string name, input mod113_pkg::residue_t got,
                               input mod113_pkg::residue_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      stop_with_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic read_trace();
    int fd;
    string line;
    mod113_pkg::operand_t op;
    mod113_pkg::residue_t exp;
    fd = $fopen("test/mod113_trace.txt", "r");
    if (fd == 0)
      stop_with_failure("Could not open the trace file test/mod113_trace.txt");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      // Skip comment and blank lines
      if (line.len() > 2 && line[0] != "/")
      begin
        if ($sscanf(line, "%h %h", op, exp) == 2)
        begin
          ops.push_back(op);
          exps.push_back(exp);
        end
      end
    end
    $fclose(fd);
  endtask

  // Called at a falling edge, returns at the falling edge after the accepting rising edge
  task automatic send_beat(input logic [beat_w-1:0] data);
    logic taken;
    in_valid = 1'b1;
    in_data = data;
    taken = 1'b0;
    while (!taken)
    begin
      taken = in_ready; // in_ready only moves at rising edges
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic send_operand(input mod113_pkg::operand_t op,
                              input mod113_pkg::residue_t exp, input bit gaps);
    int idle;
    for (int b = 0; b < num_beats; b++)
    begin
      idle = 0;
      if (gaps && ($urandom % 4 == 0))
        idle = 1 + $urandom % 3;
      repeat (idle) @(negedge clk);
      send_beat(op[b*beat_w +: beat_w]); // Least significant beat first
    end
    exp_q.push_back(exp);
    accepted_ops++;
  endtask

  task automatic drain(input int count, input bit random_ready);
    int popped;
    popped = 0;
    while (popped < count)
    begin
      if (random_ready)
        res_ready = ($urandom % 2 == 1);
      else
        res_ready = 1'b1;
      if (res_valid && res_ready)
      begin
        if (exp_q.size() == 0)
          stop_with_failure("A result came out while no operand was outstanding");
        check_residue("res_data", res_data, exp_q.pop_front());
        popped++;
      end
      @(negedge clk);
    end
    res_ready = 1'b0;
  endtask

  task automatic watchdog(input int limit);
    repeat (limit) @(posedge clk);
    stop_with_failure($sformatf("The results did not arrive within %0d cycles", limit));
  endtask

  initial
  begin
    int n;
    int total;
    int cycles;
    int base;
    void'($urandom(32'hcac4_1369));
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    res_ready = 1'b0;
    accepted_ops = 0;
    read_trace();
    n = ops.size();
    if (n < stall_ops)
      stop_with_failure("The trace holds too few operands for the back-pressure test");
    total = 1 + n + stall_ops;
    fork
      watchdog(total * (num_beats + 40) * 4);
    join_none

    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_bit("res_valid", res_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);

    // Rising edges after the accepting one, up to the first that sees res_valid high
    res_ready = 1'b1;
    send_operand(ops[0], exps[0], 1'b0);
    cycles = 1;
    while (!res_valid && cycles < 20)
    begin
      @(negedge clk);
      cycles++;
    end
    check_count("latency", cycles, 2);
    drain(1, 1'b0);

    fork
      begin
        for (int i = 0; i < n; i++)
          send_operand(ops[i], exps[i], 1'b1);
      end
      drain(n, 1'b1);
    join

    // FIFO plus the held operand absorb fifo_depth + 1 operands
    res_ready = 1'b0;
    base = accepted_ops;
    fork
      begin
        for (int i = 0; i < stall_ops; i++)
          send_operand(ops[i % n], exps[i % n], 1'b0);
      end
      begin
        repeat ((fifo_depth + 2) * (num_beats + 4)) @(negedge clk);
        check_count("accepted operands", accepted_ops - base, fifo_depth + 1);
        check_bit("in_ready", in_ready, 1'b0);
        check_bit("res_valid", res_valid, 1'b1);
        drain(stall_ops, 1'b0);
      end
    join

    // A duplicated result would still sit in the FIFO here
    check_bit("res_valid", res_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== rtl/mod113_engine.sv ====
`timescale 1ns/1ps

module mod113_engine #(
  parameter int beat_w     = 16,
  parameter int fifo_depth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [beat_w-1:0]    in_data,
  output logic                 res_valid,
  input  logic                 res_ready,
  output mod113_pkg::residue_t res_data
);

  logic opnd_valid;
  logic opnd_ready;
  mod113_pkg::operand_t opnd;
  mod113_pkg::residue_t opnd_res;

  operand_assembler #(.beat_w(beat_w)) u_assembler (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .opnd_valid (opnd_valid),
    .opnd_ready (opnd_ready),
    .opnd       (opnd)
  );

  // Combinational, sits on the held operand
  wide_mod_reducer u_reducer (
    .opnd (opnd),
    .res  (opnd_res)
  );

  residue_fifo #(.fifo_depth(fifo_depth)) u_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_valid (opnd_valid),
    .push_ready (opnd_ready),
    .push_data  (opnd_res),
    .pop_valid  (res_valid),
    .pop_ready  (res_ready),
    .pop_data   (res_data)
  );

endmodule

// ==== rtl/residue_fifo.sv ====
`timescale 1ns/1ps

module residue_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push_valid,
  output logic                 push_ready,
  input  mod113_pkg::residue_t push_data,
  output logic                 pop_valid,
  input  logic                 pop_ready,
  output mod113_pkg::residue_t pop_data
);

  // Depth is a power of two, at least 2, so pointers wrap by themselves
  localparam int ptr_w = $clog2(fifo_depth);
  localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(fifo_depth);

  mod113_pkg::residue_t mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0] count;
  logic push;
  logic pop;

  assign push_ready = (count != full_count);
  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];
  assign push = push_valid && push_ready;
  assign pop  = pop_valid && pop_ready;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  // Full FIFO never takes a write
  assert property (@(posedge clk) disable iff (rst)
    count == full_count && !pop |=> $stable(wr_ptr) && count == full_count);

  // Reducer output is always a proper residue
  assert property (@(posedge clk) disable iff (rst)
    push |-> push_data < mod113_pkg::modulus);

  assert property (@(posedge clk) disable iff (rst) count <= full_count);

endmodule

// ==== rtl/wide_mod_reducer/wide_mod_reducer.sv ====
`timescale 1ns/1ps

module wide_mod_reducer (
  input  mod113_pkg::operand_t opnd,
  output mod113_pkg::residue_t res
);

  // Nodes per tree level when summing in groups of three
  function automatic int level_count(input int lvl);
    int n;
    n = mod113_pkg::num_chunks;
    for (int i = 0; i < lvl; i++)
      n = (n + 2) / 3;
    return n;
  endfunction

  function automatic int level_base(input int lvl);
    int base;
    base = 0;
    for (int i = 0; i < lvl; i++)
      base += level_count(i);
    return base;
  endfunction

  function automatic int tree_depth();
    int lvl;
    lvl = 0;
    while (level_count(lvl) > 1)
      lvl++;
    return lvl;
  endfunction

  // Folds needed before a single subtraction suffices
  function automatic int fold_count();
    int bound;
    int n;
    bound = mod113_pkg::num_chunks * (mod113_pkg::modulus - 1);
    n = 0;
    while (bound >= 2 * mod113_pkg::modulus)
    begin
      bound = ((bound > 127) ? 127 : bound) + mod113_pkg::fold_weight * (bound >> 7);
      n++;
    end
    return n;
  endfunction

  localparam int sum_w = $clog2(mod113_pkg::num_chunks * (mod113_pkg::modulus - 1) + 1);
  localparam int num_levels = tree_depth();
  localparam int root = level_base(num_levels);
  localparam int num_folds = fold_count();
  localparam logic [sum_w-1:0] modulus_s = sum_w'(mod113_pkg::modulus);

  logic [sum_w-1:0] node [root+1];
  logic [sum_w-1:0] folded;

  // 128 == 15 mod 113
  function automatic logic [sum_w-1:0] fold(input logic [sum_w-1:0] v);
    return sum_w'(v[mod113_pkg::residue_w-1:0]) +
           sum_w'(mod113_pkg::fold_weight) * (v >> mod113_pkg::residue_w);
  endfunction

  for (genvar k = 0; k < mod113_pkg::num_chunks; k++)
  begin : g_chunk
    localparam int lo = k * mod113_pkg::chunk_w;
    localparam int hi = (lo + mod113_pkg::chunk_w > mod113_pkg::operand_w) ?
                        mod113_pkg::operand_w - 1 : lo + mod113_pkg::chunk_w - 1;
    if (k == 0)
    begin : g_direct
      assign node[0] = sum_w'(opnd[hi:lo]); // Weight 1
    end
    else
    begin : g_table
      mod113_pkg::residue_t chunk_res;
      chunk_residue #(.chunk_index(k)) u_chunk (
        .chunk (mod113_pkg::chunk_w'(opnd[hi:lo])),
        .res   (chunk_res)
      );
      assign node[k] = sum_w'(chunk_res);
    end
  end

  for (genvar l = 1; l <= num_levels; l++)
  begin : g_level
    for (genvar j = 0; j < level_count(l); j++)
    begin : g_node
      localparam int src = level_base(l - 1) + 3 * j;
      localparam int left = level_count(l - 1) - 3 * j;
      localparam int dst = level_base(l) + j;
      if (left >= 3)
      begin : g_three
        assign node[dst] = node[src] + node[src+1] + node[src+2];
      end
      else if (left == 2)
      begin : g_two
        assign node[dst] = node[src] + node[src+1];
      end
      else
      begin : g_one
        assign node[dst] = node[src];
      end
    end
  end

  always_comb
  begin
    folded = node[root];
    for (int i = 0; i < num_folds; i++)
      folded = fold(folded);
  end

  // folded < 226 here
  assign res = (folded >= modulus_s) ? mod113_pkg::residue_t'(folded - modulus_s)
                                     : mod113_pkg::residue_t'(folded);

endmodule

// ==== rtl/wide_mod_reducer/chunk_residue.sv ====
`timescale 1ns/1ps

module chunk_residue #(
  parameter int chunk_index = 1
) (
  input  logic [mod113_pkg::chunk_w-1:0] chunk,
  output mod113_pkg::residue_t           res
);

  localparam int prod_w = mod113_pkg::chunk_w + mod113_pkg::residue_w;

  // Weight of this chunk position, already reduced
  localparam logic [mod113_pkg::residue_w-1:0] weight =
    mod113_pkg::residue_w'(mod113_pkg::chunk_weight(chunk_index));
  localparam logic [prod_w-1:0] modulus_p = prod_w'(mod113_pkg::modulus);

  logic [prod_w-1:0] product;

  // Constant weight, so this folds into a 64-entry table
  assign product = chunk * weight;
  assign res = mod113_pkg::residue_t'(product % modulus_p);

endmodule

// ==== rtl/operand_assembler.sv ====
`timescale 1ns/1ps

module operand_assembler #(
  parameter int beat_w = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic [beat_w-1:0]    in_data,
  output logic                 opnd_valid,
  input  logic                 opnd_ready,
  output mod113_pkg::operand_t opnd
);

  localparam int num_beats = mod113_pkg::operand_w / beat_w;
  localparam int cnt_w = $clog2(num_beats);
  localparam logic [cnt_w-1:0] last_beat = cnt_w'(num_beats - 1);

  logic [cnt_w-1:0] beat_cnt;
  mod113_pkg::operand_t shift_q;

  // Only one operand held at a time
  assign in_ready = !opnd_valid;
  assign opnd = shift_q;

  // Beats enter at the top, so the first beat ends up least significant
  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
      shift_q <= {in_data, shift_q[mod113_pkg::operand_w-1:beat_w]};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      beat_cnt   <= '0;
      opnd_valid <= 1'b0;
    end
    else if (opnd_valid)
    begin
      if (opnd_ready)
      begin
        opnd_valid <= 1'b0;
        beat_cnt   <= '0;
      end
    end
    else if (in_valid)
    begin
      if (beat_cnt == last_beat)
        opnd_valid <= 1'b1; // Count holds until the handshake
      else
        beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // Operand must not move under a stalled handshake
  assert property (@(posedge clk) disable iff (rst)
    opnd_valid && !opnd_ready |=> opnd_valid && $stable(opnd));

endmodule

// ==== common/mod113_pkg.sv ====
package mod113_pkg;

  localparam int operand_w = 400;
  localparam int chunk_w = 6;
  localparam int num_chunks = (operand_w + chunk_w - 1) / chunk_w; // Top chunk has 4 bits
  localparam int residue_w = 7;
  localparam int modulus = 113;
  localparam int fold_weight = (1 << residue_w) % modulus;        // 128 mod 113 = 15

  typedef logic [residue_w-1:0] residue_t;
  typedef logic [operand_w-1:0] operand_t;

  // 2^(chunk_w*index) mod 113, by repeated doubling so it stays small at elaboration
  function automatic int chunk_weight(input int index);
    int w;
    w = 1;
    for (int i = 0; i < chunk_w * index; i++)
    begin
      w = w * 2;
      if (w >= modulus)
        w = w - modulus;
    end
    return w;
  endfunction

endpackage
